// File: filelist.f
+incdir+verif
rtl/inv_pkg.sv
rtl/inv_ifs.sv
rtl/axil_regs.sv
rtl/matrix_store.sv
rtl/row_combine.sv
rtl/elim_ctrl.sv
rtl/mat_inv_top.sv
verif/tb_clk_gen.sv
verif/mat_inv_tb.sv

// File: Makefile
TOP = mat_inv_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
		--top-module $(TOP) -f filelist.f

# Fails unless the pass line shows up in the simulator output
run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf obj_dir

// File: verif/inv_ref_model.svh
`ifndef INV_REF_MODEL_SVH
`define INV_REF_MODEL_SVH

// Augmented matrix worked on by the software model
logic [DATA_W-1:0] model_mat [MAT_N][AUG_COLS];

// Row i becomes a_kk * row_i - a_ik * row_k, wrapping at 32 bits
function automatic void combine_rows(input int k, input int i);
	logic [DATA_W-1:0] akk;
	logic [DATA_W-1:0] aik;
	akk = model_mat[k][k];
	aik = model_mat[i][k];
	for (int c = 0; c < AUG_COLS; c++)
	begin
		model_mat[i][c] = akk * model_mat[i][c] - aik * model_mat[k][c];
	end
endfunction

// Fraction-free Gauss-Jordan on model_mat, left half already loaded
task automatic invert_reference(output bit sing);
	logic [DATA_W-1:0] tmp;
	int                p;
	sing = 1'b0;
	for (int r = 0; r < MAT_N; r++)
	begin
		for (int c = 0; c < MAT_N; c++)
		begin
			model_mat[r][MAT_N + c] = (r == c) ? DATA_W'(1) : '0;
		end
	end

	//////////////////////////////
	// Forward pass
	//////////////////////////////
	for (int k = 0; k < MAT_N; k++)
	begin
		p = -1;
		for (int r = k; r < MAT_N; r++)
		begin
			if ((p < 0) && (model_mat[r][k] != '0))
				p = r;
		end
		if (p < 0)
		begin
			// No pivot anywhere in this column, stop here
			sing = 1'b1;
			break;
		end
		if (p != k)
		begin
			for (int c = 0; c < AUG_COLS; c++)
			begin
				tmp             = model_mat[k][c];
				model_mat[k][c] = model_mat[p][c];
				model_mat[p][c] = tmp;
			end
		end
		for (int i = k + 1; i < MAT_N; i++)
		begin
			combine_rows(k, i);
		end
	end

	//////////////////////////////
	// Backward pass
	//////////////////////////////
	if (!sing)
	begin
		for (int k = MAT_N - 1; k > 0; k--)
		begin
			for (int i = 0; i < k; i++)
			begin
				combine_rows(k, i);
			end
		end
	end
endtask

`endif

// File: verif/mat_inv_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mat_inv_tb;
	import inv_pkg::*;

	localparam int          NUM_ENTRIES    = 6;
	localparam int          RESET_CYCLES   = 10;
	localparam int          TIMEOUT_CYCLES = 3000 * NUM_ENTRIES + RESET_CYCLES;
	localparam logic [31:0] SEED           = 32'h5f3a84bb;

	logic                  clk;
	logic                  arst_n;
	logic [AXI_ADDR_W-1:0] s_awaddr;
	logic                  s_awvalid;
	logic                  s_awready;
	logic [DATA_W-1:0]     s_wdata;
	logic [DATA_W/8-1:0]   s_wstrb;
	logic                  s_wvalid;
	logic                  s_wready;
	logic [1:0]            s_bresp;
	logic                  s_bvalid;
	logic                  s_bready;
	logic [AXI_ADDR_W-1:0] s_araddr;
	logic                  s_arvalid;
	logic                  s_arready;
	logic [DATA_W-1:0]     s_rdata;
	logic [1:0]            s_rresp;
	logic                  s_rvalid;
	logic                  s_rready;

	int                    check_count = 0;
	int                    error_count = 0;
	int                    cycle_count = 0;
	bit                    stall_en    = 1'b0;
	logic [DATA_W-1:0]     exp_status  = '0;

	//////////////////////////////
	// Stimulus table
	//////////////////////////////
	// Reference, identity, swaps in columns 0 and 1, singular, two random
	logic [DATA_W-1:0] stim_a [NUM_ENTRIES][MAT_N*MAT_N] = '{
		'{2, 1, 1, 3, 2,  1, 2, 2, 1, 1,  1, 2, 9, 1, 5,  3, 1, 1, 7, 1,  2, 1, 5, 1, 8},
		'{1, 0, 0, 0, 0,  0, 1, 0, 0, 0,  0, 0, 1, 0, 0,  0, 0, 0, 1, 0,  0, 0, 0, 0, 1},
		'{0, 1, 0, 2, 1,  0, 0, 1, 0, 3,  1, 2, 0, 0, 0,  0, 0, 0, 1, 2,  2, 1, 3, 0, 1},
		'{0, 1, 2, 3, 4,  0, 5, 6, 7, 8,  0, 1, 1, 1, 1,  0, 2, 3, 4, 5,  0, 9, 8, 7, 6},
		'{default: 32'd0},
		'{default: 32'd0}
	};
	bit stim_rand  [NUM_ENTRIES] = '{0, 0, 0, 0, 1, 1};
	bit stim_stall [NUM_ENTRIES] = '{1, 0, 1, 0, 0, 1};
	bit stim_poke  [NUM_ENTRIES] = '{1, 1, 0, 0, 0, 0};
	// Expected singular flag or -1 when the model decides
	int exp_sing   [NUM_ENTRIES] = '{-1, 0, -1, 1, -1, -1};

	tb_clk_gen u_clk_gen (
		.clk    (clk),
		.arst_n (arst_n)
	);

	mat_inv_top u_dut (
		.clk       (clk),
		.arst_n    (arst_n),
		.s_awaddr  (s_awaddr),
		.s_awvalid (s_awvalid),
		.s_awready (s_awready),
		.s_wdata   (s_wdata),
		.s_wstrb   (s_wstrb),
		.s_wvalid  (s_wvalid),
		.s_wready  (s_wready),
		.s_bresp   (s_bresp),
		.s_bvalid  (s_bvalid),
		.s_bready  (s_bready),
		.s_araddr  (s_araddr),
		.s_arvalid (s_arvalid),
		.s_arready (s_arready),
		.s_rdata   (s_rdata),
		.s_rresp   (s_rresp),
		.s_rvalid  (s_rvalid),
		.s_rready  (s_rready)
	);

	`include "inv_ref_model.svh"

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
		end
	endtask

	function automatic logic [AXI_ADDR_W-1:0] elem_addr(input int r, input int c);
		return ADDR_ELEM_BASE + AXI_ADDR_W'(4 * (r * AUG_COLS + c));
	endfunction

	//////////////////////////////
	// AXI4-Lite master
	//////////////////////////////
	task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		bit aw_ok;
		bit w_ok;
		int hold;
		aw_ok = 1'b0;
		w_ok  = 1'b0;
		@(posedge clk);
		s_awaddr  <= addr;
		s_awvalid <= 1'b1;
		s_wdata   <= data;
		s_wstrb   <= '1;
		s_wvalid  <= 1'b1;
		s_bready  <= !stall_en;
		while (!(aw_ok && w_ok))
		begin
			@(posedge clk);
			if (!aw_ok && s_awready)
			begin
				aw_ok = 1'b1;
				s_awvalid <= 1'b0;
			end
			if (!w_ok && s_wready)
			begin
				w_ok = 1'b1;
				s_wvalid <= 1'b0;
			end
		end
		do @(posedge clk); while (!s_bvalid);
		if (stall_en)
		begin
			// Response has to sit there until bready
			hold = $urandom_range(6, 1);
			repeat (hold)
			begin
				@(posedge clk);
				check_value("s_bvalid", 32'(s_bvalid), 32'd1);
			end
			s_bready <= 1'b1;
			@(posedge clk);
			check_value("s_bvalid", 32'(s_bvalid), 32'd1);
		end
		check_value("s_bresp", 32'(s_bresp), 32'(OKAY));
	endtask

	task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
		int hold;
		@(posedge clk);
		s_araddr  <= addr;
		s_arvalid <= 1'b1;
		s_rready  <= !stall_en;
		do @(posedge clk); while (!s_arready);
		s_arvalid <= 1'b0;
		do @(posedge clk); while (!s_rvalid);
		data = s_rdata;
		if (stall_en)
		begin
			hold = $urandom_range(6, 1);
			repeat (hold)
			begin
				@(posedge clk);
				check_value("s_rvalid", 32'(s_rvalid), 32'd1);
				check_value("s_rdata", s_rdata, data);
			end
			s_rready <= 1'b1;
			@(posedge clk);
			check_value("s_rvalid", 32'(s_rvalid), 32'd1);
			check_value("s_rdata", s_rdata, data);
		end
		check_value("s_rresp", 32'(s_rresp), 32'(OKAY));
	endtask

	task automatic wait_done(output logic [DATA_W-1:0] status);
		do
		begin
			axi_read(ADDR_STATUS, status);
		end
		while (!status[1]);
	endtask

	//////////////////////////////
	// One table entry
	//////////////////////////////
	task automatic test_entry(input int e);
		logic [DATA_W-1:0] rd;
		bit                sing;
		bit                want_sing;
		$display("Entry %0d", e);
		for (int r = 0; r < MAT_N; r++)
		begin
			for (int c = 0; c < MAT_N; c++)
			begin
				model_mat[r][c] = stim_rand[e] ? $urandom_range(3, 0) : stim_a[e][r * MAT_N + c];
			end
		end

		stall_en = stim_stall[e];
		for (int r = 0; r < MAT_N; r++)
		begin
			for (int c = 0; c < MAT_N; c++)
			begin
				axi_write(elem_addr(r, c), model_mat[r][c]);
			end
		end
		// Left half reads back as loaded
		for (int r = 0; r < MAT_N; r++)
		begin
			for (int c = 0; c < MAT_N; c++)
			begin
				axi_read(elem_addr(r, c), rd);
				check_value($sformatf("elem[%0d][%0d]", r, c), rd, model_mat[r][c]);
			end
		end
		// STATUS is read only
		axi_write(ADDR_STATUS, 32'hffff_ffff);
		axi_read(ADDR_STATUS, rd);
		check_value("STATUS", rd, exp_status);

		invert_reference(sing);
		stall_en = 1'b0;
		axi_write(ADDR_CTRL, 32'h1);
		if (stim_poke[e])
		begin
			axi_read(ADDR_STATUS, rd);
			check_value("STATUS", rd, 32'h1);
			// Dropped since the engine owns the matrix
			axi_write(elem_addr(2, 3), 32'hdead_beef);
		end
		wait_done(rd);
		want_sing  = (exp_sing[e] < 0) ? sing : (exp_sing[e] != 0);
		exp_status = 32'({want_sing, 2'b10});
		check_value("STATUS", rd, exp_status);

		for (int r = 0; r < MAT_N; r++)
		begin
			for (int c = 0; c < AUG_COLS; c++)
			begin
				axi_read(elem_addr(r, c), rd);
				check_value($sformatf("elem[%0d][%0d]", r, c), rd, model_mat[r][c]);
			end
		end
		// Same reads again under back-pressure
		stall_en = 1'b1;
		for (int r = 0; r < MAT_N; r++)
		begin
			for (int c = 0; c < AUG_COLS; c++)
			begin
				axi_read(elem_addr(r, c), rd);
				check_value($sformatf("elem[%0d][%0d]", r, c), rd, model_mat[r][c]);
			end
		end
		stall_en = 1'b0;
	endtask

	//////////////////////////////
	// Watchdog
	//////////////////////////////
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES)
		begin
			$display("Timeout: DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Checks: %0d, errors: %0d", check_count, error_count);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial
	begin
		logic [DATA_W-1:0] rd;
		s_awaddr  = '0;
		s_awvalid = 1'b0;
		s_wdata   = '0;
		s_wstrb   = '0;
		s_wvalid  = 1'b0;
		s_bready  = 1'b0;
		s_araddr  = '0;
		s_arvalid = 1'b0;
		s_rready  = 1'b0;
		void'($urandom(SEED));

		@(posedge arst_n);
		@(posedge clk);
		// Straight out of reset
		axi_read(ADDR_STATUS, rd);
		check_value("STATUS", rd, '0);
		axi_read(elem_addr(0, 0), rd);
		check_value("elem[0][0]", rd, '0);
		axi_read(elem_addr(MAT_N - 1, AUG_COLS - 1), rd);
		check_value("elem[4][9]", rd, '0);

		for (int e = 0; e < NUM_ENTRIES; e++)
		begin
			test_entry(e);
		end

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
	output logic clk,
	output logic arst_n
);
	localparam int HALF_PERIOD  = 2;
	localparam int RESET_CYCLES = 10;

	initial
	begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial
	begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// File: rtl/mat_inv_top.sv
`timescale 1ns/1ns
`default_nettype none

module mat_inv_top (
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic [inv_pkg::AXI_ADDR_W-1:0] s_awaddr,
	input  logic                           s_awvalid,
	output logic                           s_awready,
	input  logic [inv_pkg::DATA_W-1:0]     s_wdata,
	input  logic [inv_pkg::DATA_W/8-1:0]   s_wstrb,
	input  logic                           s_wvalid,
	output logic                           s_wready,
	output logic [1:0]                     s_bresp,
	output logic                           s_bvalid,
	input  logic                           s_bready,
	input  logic [inv_pkg::AXI_ADDR_W-1:0] s_araddr,
	input  logic                           s_arvalid,
	output logic                           s_arready,
	output logic [inv_pkg::DATA_W-1:0]     s_rdata,
	output logic [1:0]                     s_rresp,
	output logic                           s_rvalid,
	input  logic                           s_rready
);
	import inv_pkg::*;

	logic              start;
	logic              busy;
	logic              done;
	logic              singular;
	logic [DATA_W-1:0] pivot;
	logic [DATA_W-1:0] factor;
	row_t              new_row;

	elem_if elem ();
	row_if  rows ();

	axil_regs u_regs (
		.clk       (clk),
		.arst_n    (arst_n),
		.s_awaddr  (s_awaddr),
		.s_awvalid (s_awvalid),
		.s_awready (s_awready),
		.s_wdata   (s_wdata),
		.s_wstrb   (s_wstrb),
		.s_wvalid  (s_wvalid),
		.s_wready  (s_wready),
		.s_bresp   (s_bresp),
		.s_bvalid  (s_bvalid),
		.s_bready  (s_bready),
		.s_araddr  (s_araddr),
		.s_arvalid (s_arvalid),
		.s_arready (s_arready),
		.s_rdata   (s_rdata),
		.s_rresp   (s_rresp),
		.s_rvalid  (s_rvalid),
		.s_rready  (s_rready),
		.elem      (elem.host),
		.start     (start),
		.busy      (busy),
		.done      (done),
		.singular  (singular)
	);

	matrix_store u_store (
		.clk     (clk),
		.arst_n  (arst_n),
		.elem    (elem.store),
		.rows    (rows.store),
		.new_row (new_row)
	);

	elim_ctrl u_ctrl (
		.clk      (clk),
		.arst_n   (arst_n),
		.start    (start),
		.rows     (rows.ctrl),
		.busy     (busy),
		.done     (done),
		.singular (singular),
		.pivot    (pivot),
		.factor   (factor)
	);

	// Row datapath fed straight from the store's two row ports
	row_combine u_combine (
		.clk        (clk),
		.arst_n     (arst_n),
		.pivot_row  (rows.row_a),
		.target_row (rows.row_b),
		.pivot      (pivot),
		.factor     (factor),
		.result     (new_row)
	);

endmodule

`default_nettype wire

// File: rtl/elim_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module elim_ctrl (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       start,
	row_if.ctrl                        rows,
	output logic                       busy,
	output logic                       done,
	output logic                       singular,
	output logic [inv_pkg::DATA_W-1:0] pivot,
	output logic [inv_pkg::DATA_W-1:0] factor
);
	import inv_pkg::*;

	elim_state_t          state;
	logic [ROW_IDX_W-1:0] k;
	logic [ROW_IDX_W-1:0] i;
	logic                 pivot_found;

	// Row k is always the pivot row, row i the one being worked on
	assign rows.sel_a   = k;
	assign rows.sel_b   = i;
	assign rows.init_en = (state == INIT);
	assign rows.swap_en = (state == SWAP);
	assign rows.wr_en   = (state == FWD_WR) || (state == BWD_WR);

	assign pivot  = rows.row_a[k];
	assign factor = rows.row_b[k];
	// During search the candidate entry is the same as the factor lane
	assign pivot_found = (factor != '0);

	//////////////////////////////
	// Sequencer
	//////////////////////////////
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state    <= IDLE;
			k        <= '0;
			i        <= '0;
			busy     <= 1'b0;
			done     <= 1'b0;
			singular <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (start)
					begin
						busy     <= 1'b1;
						done     <= 1'b0;
						singular <= 1'b0;
						state    <= INIT;
					end
				end
				INIT:
				begin
					k     <= '0;
					i     <= '0;
					state <= SEARCH;
				end
				SEARCH:
				begin
					if (pivot_found)
					begin
						if (i != k)
						begin
							state <= SWAP;
						end
						else if (k == LAST_ROW)
						begin
							// Last column has nothing below, go back up
							i     <= '0;
							state <= BWD_RD;
						end
						else
						begin
							i     <= k + 1'b1;
							state <= FWD_RD;
						end
					end
					else if (i == LAST_ROW)
					begin
						singular <= 1'b1;
						state    <= FINISH;
					end
					else
					begin
						i <= i + 1'b1;
					end
				end
				// Only reached with k below the last row
				SWAP:
				begin
					i     <= k + 1'b1;
					state <= FWD_RD;
				end
				FWD_RD:
					state <= FWD_WR;
				FWD_WR:
				begin
					if (i != LAST_ROW)
					begin
						i     <= i + 1'b1;
						state <= FWD_RD;
					end
					else
					begin
						k     <= k + 1'b1;
						i     <= k + 1'b1;
						state <= SEARCH;
					end
				end
				BWD_RD:
					state <= BWD_WR;
				BWD_WR:
				begin
					if (i != k - 1'b1)
					begin
						i     <= i + 1'b1;
						state <= BWD_RD;
					end
					else if (k == ROW_IDX_W'(1))
					begin
						state <= FINISH;
					end
					else
					begin
						k     <= k - 1'b1;
						i     <= '0;
						state <= BWD_RD;
					end
				end
				FINISH:
				begin
					busy  <= 1'b0;
					done  <= 1'b1;
					state <= IDLE;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/row_combine.sv
`timescale 1ns/1ns
`default_nettype none

module row_combine (
	input  logic                       clk,
	input  logic                       arst_n,
	input  inv_pkg::row_t              pivot_row,
	input  inv_pkg::row_t              target_row,
	input  logic [inv_pkg::DATA_W-1:0] pivot,
	input  logic [inv_pkg::DATA_W-1:0] factor,
	output inv_pkg::row_t              result
);
	import inv_pkg::*;

	row_t result_d;

	// a_kk * row_i - a_ik * row_k, one lane per column
	for (genvar c = 0; c < AUG_COLS; c++)
	begin : g_col
		logic [DATA_W-1:0] scaled_target;
		logic [DATA_W-1:0] scaled_pivot;

		// Products keep the low word only
		assign scaled_target = pivot * target_row[c];
		assign scaled_pivot  = factor * pivot_row[c];
		assign result_d[c]   = scaled_target - scaled_pivot;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			result <= '0;
		else
			result <= result_d;
	end

endmodule

`default_nettype wire

// File: rtl/matrix_store.sv
`timescale 1ns/1ns
`default_nettype none

module matrix_store (
	input  logic          clk,
	input  logic          arst_n,
	elem_if.store         elem,
	row_if.store          rows,
	input  inv_pkg::row_t new_row
);
	import inv_pkg::*;

	row_t mat [MAT_N];

	//////////////////////////////
	// Read ports
	//////////////////////////////
	always_comb
	begin
		if ((elem.sel_row < MAT_N) && (elem.sel_col < AUG_COLS))
			elem.elem_rdata = mat[elem.sel_row][elem.sel_col];
		else
			elem.elem_rdata = '0;
	end

	// Pivot row and target row for the engine
	always_comb
	begin
		rows.row_a = (rows.sel_a < MAT_N) ? mat[rows.sel_a] : '0;
		rows.row_b = (rows.sel_b < MAT_N) ? mat[rows.sel_b] : '0;
	end

	//////////////////////////////
	// Update
	//////////////////////////////
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int r = 0; r < MAT_N; r++)
			begin
				mat[r] <= '0;
			end
		end
		else if (rows.init_en)
		begin
			// Right half becomes the identity, A is left alone
			for (int r = 0; r < MAT_N; r++)
			begin
				for (int c = MAT_N; c < AUG_COLS; c++)
				begin
					mat[r][c] <= (c == r + MAT_N) ? DATA_W'(1) : '0;
				end
			end
		end
		else if (rows.swap_en)
		begin
			mat[rows.sel_a] <= mat[rows.sel_b];
			mat[rows.sel_b] <= mat[rows.sel_a];
		end
		else if (rows.wr_en)
		begin
			mat[rows.sel_b] <= new_row;
		end
		else if (elem.we)
		begin
			mat[elem.sel_row][elem.sel_col] <= elem.wdata;
		end
	end

endmodule

`default_nettype wire

// File: rtl/axil_regs.sv
`timescale 1ns/1ns
`default_nettype none

module axil_regs (
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic [inv_pkg::AXI_ADDR_W-1:0] s_awaddr,
	input  logic                           s_awvalid,
	output logic                           s_awready,
	input  logic [inv_pkg::DATA_W-1:0]     s_wdata,
	input  logic [inv_pkg::DATA_W/8-1:0]   s_wstrb,
	input  logic                           s_wvalid,
	output logic                           s_wready,
	output logic [1:0]                     s_bresp,
	output logic                           s_bvalid,
	input  logic                           s_bready,
	input  logic [inv_pkg::AXI_ADDR_W-1:0] s_araddr,
	input  logic                           s_arvalid,
	output logic                           s_arready,
	output logic [inv_pkg::DATA_W-1:0]     s_rdata,
	output logic [1:0]                     s_rresp,
	output logic                           s_rvalid,
	input  logic                           s_rready,
	elem_if.host                           elem,
	output logic                           start,
	input  logic                           busy,
	input  logic                           done,
	input  logic                           singular
);
	import inv_pkg::*;

	logic [AXI_ADDR_W-1:0] awaddr_q;
	logic [AXI_ADDR_W-1:0] araddr_q;
	logic [DATA_W-1:0]     wdata_q;
	logic [DATA_W/8-1:0]   wstrb_q;
	logic                  aw_done;
	logic                  w_done;
	logic                  ar_pend;
	logic                  commit;
	logic [AXI_ADDR_W-1:0] elem_addr;
	logic [AXI_ADDR_W-1:0] elem_off;
	logic [AXI_ADDR_W-3:0] elem_word;
	logic                  elem_hit;
	logic [DATA_W-1:0]     wmask;
	logic [DATA_W-1:0]     status;
	logic [DATA_W-1:0]     rd_value;

	// Both write channels in hand and the response slot is free
	assign commit  = aw_done && w_done && !s_bvalid;
	assign s_bresp = OKAY;
	assign s_rresp = OKAY;
	assign status  = {{(DATA_W - 3){1'b0}}, singular, done, busy};

	//////////////////////////////
	// Element window decode
	//////////////////////////////
	always_comb
	begin
		elem_addr = commit ? awaddr_q : araddr_q;
		elem_off  = elem_addr - ADDR_ELEM_BASE;
		elem_word = elem_off[AXI_ADDR_W-1:2];
		elem_hit  = (elem_addr >= ADDR_ELEM_BASE) && (elem_word < ELEM_WORDS);
		for (int b = 0; b < DATA_W / 8; b++)
		begin
			wmask[8*b +: 8] = {8{wstrb_q[b]}};
		end
	end

	assign elem.sel_row = ROW_IDX_W'(elem_word / AUG_COLS);
	assign elem.sel_col = COL_IDX_W'(elem_word % AUG_COLS);
	// Byte lanes not strobed keep the stored value
	assign elem.wdata   = (elem.elem_rdata & ~wmask) | (wdata_q & wmask);
	assign elem.we      = commit && elem_hit && !busy;

	always_comb
	begin
		if (araddr_q == ADDR_STATUS)
			rd_value = status;
		else if (elem_hit)
			rd_value = elem.elem_rdata;
		else
			rd_value = '0;
	end

	//////////////////////////////
	// Write channels
	//////////////////////////////
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			s_awready <= 1'b0;
			s_wready  <= 1'b0;
			s_bvalid  <= 1'b0;
			aw_done   <= 1'b0;
			w_done    <= 1'b0;
			start     <= 1'b0;
		end
		else
		begin
			s_awready <= s_awvalid && !s_awready && !aw_done && !s_bvalid;
			s_wready  <= s_wvalid && !s_wready && !w_done && !s_bvalid;
			start     <= commit && (awaddr_q == ADDR_CTRL) && wstrb_q[0] && wdata_q[0] && !busy;
			if (s_awvalid && s_awready)
				aw_done <= 1'b1;
			if (s_wvalid && s_wready)
				w_done <= 1'b1;
			if (commit)
			begin
				aw_done  <= 1'b0;
				w_done   <= 1'b0;
				s_bvalid <= 1'b1;
			end
			else if (s_bvalid && s_bready)
			begin
				s_bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (s_awvalid && s_awready)
			awaddr_q <= s_awaddr;
		if (s_wvalid && s_wready)
		begin
			wdata_q <= s_wdata;
			wstrb_q <= s_wstrb;
		end
		if (s_arvalid && s_arready)
			araddr_q <= s_araddr;
	end

	//////////////////////////////
	// Read channel
	//////////////////////////////
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			s_arready <= 1'b0;
			s_rvalid  <= 1'b0;
			s_rdata   <= '0;
			ar_pend   <= 1'b0;
		end
		else
		begin
			s_arready <= s_arvalid && !s_arready && !ar_pend && !s_rvalid;
			if (s_arvalid && s_arready)
			begin
				ar_pend <= 1'b1;
			end
			else if (ar_pend && !commit)
			begin
				// Lookup waits while a write owns the element port
				ar_pend  <= 1'b0;
				s_rvalid <= 1'b1;
				s_rdata  <= rd_value;
			end
			if (s_rvalid && s_rready)
				s_rvalid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: rtl/inv_ifs.sv
`timescale 1ns/1ns
`default_nettype none

// Host access to single elements
interface elem_if;
	import inv_pkg::*;

	logic [ROW_IDX_W-1:0] sel_row;
	logic [COL_IDX_W-1:0] sel_col;
	logic [DATA_W-1:0]    wdata;
	logic                 we;
	logic [DATA_W-1:0]    elem_rdata;

	modport host (output sel_row, sel_col, wdata, we, input elem_rdata);
	modport store (input sel_row, sel_col, wdata, we, output elem_rdata);
endinterface

// Engine access to whole rows
interface row_if;
	import inv_pkg::*;

	logic [ROW_IDX_W-1:0] sel_a;
	logic [ROW_IDX_W-1:0] sel_b;
	logic                 wr_en;
	logic                 swap_en;
	logic                 init_en;
	row_t                 row_a;
	row_t                 row_b;

	modport ctrl (output sel_a, sel_b, wr_en, swap_en, init_en, input row_a, row_b);
	modport store (input sel_a, sel_b, wr_en, swap_en, init_en, output row_a, row_b);
endinterface

`default_nettype wire

// File: rtl/inv_pkg.sv
`default_nettype none

package inv_pkg;

	//////////////////////////////
	// Matrix geometry
	//////////////////////////////
	localparam int MAT_N      = 5;
	localparam int AUG_COLS   = 2 * MAT_N;
	localparam int DATA_W     = 32;
	localparam int ROW_IDX_W  = 3;
	localparam int COL_IDX_W  = 4;
	localparam int ELEM_WORDS = MAT_N * AUG_COLS;

	localparam logic [ROW_IDX_W-1:0] LAST_ROW = ROW_IDX_W'(MAT_N - 1);

	// One augmented row, left half is A and right half the inverse
	typedef logic [AUG_COLS-1:0][DATA_W-1:0] row_t;

	//////////////////////////////
	// Register map
	//////////////////////////////
	localparam int AXI_ADDR_W = 12;

	localparam logic [AXI_ADDR_W-1:0] ADDR_CTRL      = 12'h000;
	localparam logic [AXI_ADDR_W-1:0] ADDR_STATUS    = 12'h004;
	localparam logic [AXI_ADDR_W-1:0] ADDR_ELEM_BASE = 12'h100;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} resp_t;

	// Sequencer states
	typedef enum logic [3:0] {
		IDLE, INIT, SEARCH, SWAP, FWD_RD, FWD_WR, BWD_RD, BWD_WR, FINISH
	} elim_state_t;

endpackage

`default_nettype wire
